// ==== project.f ====
+incdir+rtl
rtl/fetch_pkg.sv
rtl/bank_if.sv
rtl/buffer_bank.sv
rtl/buffer_ctrl.sv
rtl/fetch_pc.sv
rtl/fetch_unit.sv
tests/tb_clock.sv
tests/tb_imem.sv
tests/tb_fetch_unit.sv

// ==== rtl/bank_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

interface bank_if import fetch_pkg::*; ();

  logic          [`FETCH_LANES-1:0] wen;
  lane_addr_t    [`FETCH_LANES-1:0] waddr;
  parcel_entry_t [`FETCH_LANES-1:0] wdata;
  lane_addr_t    [`FETCH_LANES-1:0] raddr;
  parcel_entry_t [`FETCH_LANES-1:0] rdata;

  modport ctrl (
    output wen,
    output waddr,
    output wdata,
    output raddr,
    input  rdata
  );

  modport bank (
    input  wen,
    input  waddr,
    input  wdata,
    input  raddr,
    output rdata
  );

endinterface

`default_nettype wire

// ==== rtl/buffer_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module buffer_bank import fetch_pkg::*; (
  input logic  clock,
  bank_if.bank bank
);

  for (genvar i = 0; i < `FETCH_LANES; i++) begin : g_lane
    parcel_entry_t mem [`FETCH_DEPTH];

    always_ff @(posedge clock) begin
      if (bank.wen[i]) begin
        mem[bank.waddr[i]] <= bank.wdata[i];
      end
    end

    // a parcel written this cycle is visible at once.
    assign bank.rdata[i] = (bank.wen[i] && (bank.raddr[i] == bank.waddr[i])) ?
                           bank.wdata[i] : mem[bank.raddr[i]];
  end

endmodule

`default_nettype wire

// ==== rtl/buffer_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module buffer_ctrl import fetch_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  fetch_block_t block,
  input  logic         clear,
  input  logic         align_pc,
  input  logic         issue_stall,
  output logic         full,
  bank_if.ctrl         bank,
  output logic         slot0_valid,
  output logic         slot1_valid,
  output logic [31:0]  slot0_pc,
  output logic [31:0]  slot1_pc,
  output logic [31:0]  slot0_instr,
  output logic [31:0]  slot1_instr
);

  localparam int PTR_BITS = `FETCH_ADDR_BITS + 2;
  localparam int CAPACITY = `FETCH_LANES * `FETCH_DEPTH;

  localparam logic [PTR_BITS-1:0] PTR_STEP = 4;
  localparam logic [PTR_BITS:0] COUNT_STEP = 4;

  // parcel-granular pointers.
  logic [PTR_BITS-1:0]     wptr;
  logic [PTR_BITS-1:0]     rptr;
  logic [PTR_BITS:0]       count;

  logic [PTR_BITS-1:0]     wptr_cur;
  logic [PTR_BITS-1:0]     rptr_cur;
  logic [PTR_BITS:0]       count_cur;
  logic                    wen;
  logic                    take_align;
  logic [PTR_BITS-1:0]     rd_base;
  logic [PTR_BITS:0]       avail;
  lane_addr_t              rd_entry;
  logic [1:0]              rd_off;
  parcel_entry_t           parcel [`FETCH_LANES];
  logic [`FETCH_LANES-1:0] comp;
  logic [2:0]              len0;
  logic [2:0]              len1;
  logic [1:0]              lane1;
  logic [2:0]              used;
  logic [PTR_BITS-1:0]     wptr_next;
  logic [PTR_BITS-1:0]     rptr_next;
  logic [PTR_BITS:0]       count_next;

  // redirect empties the buffer in the same cycle.
  assign wptr_cur   = clear ? '0 : wptr;
  assign rptr_cur   = clear ? '0 : rptr;
  assign count_cur  = clear ? '0 : count;

  assign wen        = block.valid & ~clear;
  assign take_align = wen & align_pc;

  // first block after a redirect sets the read offset.
  assign rd_base  = take_align ? {wptr_cur[PTR_BITS-1:2], block.pc[2:1]} : rptr_cur;
  assign rd_entry = rd_base[PTR_BITS-1:2];
  assign rd_off   = rd_base[1:0];

  always_comb begin
    avail = count_cur;
    if (wen) begin
      avail = avail + COUNT_STEP;
    end
    if (take_align) begin
      avail = avail - {{(PTR_BITS-1){1'b0}}, block.pc[2:1]};
    end
  end

  always_comb begin
    for (int i = 0; i < `FETCH_LANES; i++) begin
      bank.wen[i]          = wen;
      bank.waddr[i]        = wptr_cur[PTR_BITS-1:2];
      bank.wdata[i].pc     = {block.pc[31:3], 2'(i), 1'b0};
      bank.wdata[i].parcel = block.data[16*i +: 16];
    end
  end

  always_comb begin
    for (int i = 0; i < `FETCH_LANES; i++) begin
      // lanes below the offset hold the next entry.
      if (i < rd_off) begin
        bank.raddr[i] = rd_entry + lane_addr_t'(1);
      end else begin
        bank.raddr[i] = rd_entry;
      end
    end
  end

  // program order.
  always_comb begin
    for (int k = 0; k < `FETCH_LANES; k++) begin
      parcel[k] = bank.rdata[2'(rd_off + k)];
      comp[k]   = ~&parcel[k].parcel[1:0];
    end
  end

  always_comb begin
    len0  = comp[0] ? 3'd1 : 3'd2;
    lane1 = len0[1:0];
    len1  = comp[lane1] ? 3'd1 : 3'd2;

    // lanes past the buffered parcels never decide a valid.
    slot0_valid = ~issue_stall & (avail != '0) & (avail >= len0);
    slot1_valid = slot0_valid & (avail > len0) & (avail >= len0 + len1);

    slot0_pc = parcel[0].pc;
    if (comp[0]) begin
      slot0_instr = {16'b0, parcel[0].parcel};
    end else begin
      slot0_instr = {parcel[1].parcel, parcel[0].parcel};
    end

    slot1_pc = parcel[lane1].pc;
    if (comp[lane1]) begin
      slot1_instr = {16'b0, parcel[lane1].parcel};
    end else begin
      slot1_instr = {parcel[lane1 + 2'd1].parcel, parcel[lane1].parcel};
    end

    used = 3'd0;
    if (slot1_valid) begin
      used = len0 + len1;
    end else if (slot0_valid) begin
      used = len0;
    end
  end

  always_comb begin
    wptr_next  = wen ? wptr_cur + PTR_STEP : wptr_cur;
    rptr_next  = rd_base + {{(PTR_BITS-3){1'b0}}, used};
    count_next = avail - {{(PTR_BITS-2){1'b0}}, used};
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      wptr  <= wptr_next;
      rptr  <= rptr_next;
      count <= count_next;
    end
  end

  assign full = int'(count) > CAPACITY - `FETCH_FULL_MARGIN;

endmodule

`default_nettype wire

// ==== rtl/fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// entries per lane.
`define FETCH_DEPTH 8

// log2 of the lane depth.
`define FETCH_ADDR_BITS 3

// one 8-byte block holds four parcels.
`define FETCH_LANES 4

// free parcels kept back for an in-flight block.
`define FETCH_FULL_MARGIN 8

`endif

// ==== rtl/fetch_pc.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_pc import fetch_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         redirect,
  input  logic [31:0]  redirect_pc,
  input  logic         full,
  output logic         mem_valid,
  output logic [31:0]  mem_addr,
  input  logic         mem_ready,
  input  logic [63:0]  mem_rdata,
  output fetch_block_t block,
  output logic         clear,
  output logic         align_pc
);

  logic        active;
  logic        outstanding;
  logic        stale;
  logic        first;
  logic [31:0] next_pc;
  logic [31:0] out_addr;
  logic        accept;

  assign mem_valid = active & ~outstanding & ~full & ~redirect;
  assign mem_addr  = {next_pc[31:3], 3'b000};

  // responses in the redirect cycle belong to the old stream.
  assign accept = mem_ready & ~stale & ~redirect;

  assign block.valid = accept;
  assign block.pc    = out_addr;
  assign block.data  = mem_rdata;

  assign clear    = redirect;
  assign align_pc = accept & first;

  always_ff @(posedge clock) begin
    if (!reset) begin
      active      <= 1'b0;
      outstanding <= 1'b0;
      stale       <= 1'b0;
      first       <= 1'b0;
    end else begin
      if (mem_valid) begin
        outstanding <= 1'b1;
      end else if (mem_ready) begin
        outstanding <= 1'b0;
      end
      if (redirect) begin
        active <= 1'b1;
        first  <= 1'b1;
        // old response still to come.
        stale  <= outstanding & ~mem_ready;
      end else if (mem_ready) begin
        stale <= 1'b0;
        if (!stale) begin
          first <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (redirect) begin
      next_pc <= redirect_pc;
    end else if (accept) begin
      next_pc <= {out_addr[31:3], 3'b000} + 32'd8;
    end
    if (mem_valid) begin
      out_addr <= next_pc;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fetch_pkg.sv ====
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

  // one 16-bit parcel tagged with its byte address.
  typedef struct packed {
    logic [31:0] pc;
    logic [15:0] parcel;
  } parcel_entry_t;

  typedef logic [`FETCH_ADDR_BITS-1:0] lane_addr_t;

  // memory block on its way into the buffer.
  typedef struct packed {
    logic [31:0] pc;
    logic [63:0] data;
    logic        valid;
  } fetch_block_t;

endpackage

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import fetch_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        redirect,
  input  logic [31:0] redirect_pc,
  input  logic        issue_stall,
  output logic        mem_valid,
  output logic [31:0] mem_addr,
  input  logic        mem_ready,
  input  logic [63:0] mem_rdata,
  output logic        slot0_valid,
  output logic [31:0] slot0_pc,
  output logic [31:0] slot0_instr,
  output logic        slot1_valid,
  output logic [31:0] slot1_pc,
  output logic [31:0] slot1_instr
);

  fetch_block_t block;
  logic         clear;
  logic         align_pc;
  logic         full;

  bank_if bank_bus ();

  fetch_pc u_fetch_pc (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .full        (full),
    .mem_valid   (mem_valid),
    .mem_addr    (mem_addr),
    .mem_ready   (mem_ready),
    .mem_rdata   (mem_rdata),
    .block       (block),
    .clear       (clear),
    .align_pc    (align_pc)
  );

  buffer_ctrl u_buffer_ctrl (
    .clock       (clock),
    .reset       (reset),
    .block       (block),
    .clear       (clear),
    .align_pc    (align_pc),
    .issue_stall (issue_stall),
    .full        (full),
    .bank        (bank_bus.ctrl),
    .slot0_valid (slot0_valid),
    .slot1_valid (slot1_valid),
    .slot0_pc    (slot0_pc),
    .slot1_pc    (slot1_pc),
    .slot0_instr (slot0_instr),
    .slot1_instr (slot1_instr)
  );

  buffer_bank u_buffer_bank (
    .clock (clock),
    .bank  (bank_bus.bank)
  );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 10
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  // active low, released just after an edge.
  initial begin
    reset = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tests/tb_fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_unit;

  localparam int CLOCK_PERIOD  = 10;
  localparam int RESET_CYCLES  = 10;
  localparam int IMAGE_PARCELS = 512;
  localparam int DELAY_SLOTS   = 64;
  localparam int IDLE_CYCLES   = 20;
  localparam int STALL_CYCLES  = 40;
  localparam int QUIET_CYCLES  = 4;
  localparam logic [31:0] REDIRECT_TARGET = 32'h0000_02a6;

  // instructions expected from each test.
  localparam int N_COMPRESSED = 100;
  localparam int N_MIXED      = 150;
  localparam int N_OLD_STREAM = 8;
  localparam int N_REDIRECT   = 60;
  localparam int N_PRE_STALL  = 20;
  localparam int N_POST_STALL = 80;
  localparam int TOTAL_INSTRS = N_COMPRESSED + N_MIXED + N_OLD_STREAM + N_REDIRECT +
                                N_PRE_STALL + N_POST_STALL;
  localparam int WATCHDOG_CYCLES = 20 * TOTAL_INSTRS + RESET_CYCLES + IDLE_CYCLES +
                                   STALL_CYCLES;

  logic        clock;
  logic        reset;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic        issue_stall;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic        mem_ready;
  logic [63:0] mem_rdata;
  logic        slot0_valid;
  logic [31:0] slot0_pc;
  logic [31:0] slot0_instr;
  logic        slot1_valid;
  logic [31:0] slot1_pc;
  logic [31:0] slot1_instr;

  string       test_name = "setup";
  logic        stream_on = 1'b0;
  logic [31:0] exp_pc = '0;
  logic [31:0] exp_fetch = '0;
  logic [31:0] first_pc = '0;
  int          issued = 0;
  int          dual_cycles = 0;
  int          straddles = 0;
  int          checks = 0;
  int          value_errors = 0;
  int          other_errors = 0;

  tb_clock #(.PERIOD(CLOCK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clock_gen (
    .clock (clock),
    .reset (reset)
  );

  tb_imem #(.PARCELS(IMAGE_PARCELS), .DELAY_SLOTS(DELAY_SLOTS)) imem (
    .clock     (clock),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata)
  );

  fetch_unit dut (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .issue_stall (issue_stall),
    .mem_valid   (mem_valid),
    .mem_addr    (mem_addr),
    .mem_ready   (mem_ready),
    .mem_rdata   (mem_rdata),
    .slot0_valid (slot0_valid),
    .slot0_pc    (slot0_pc),
    .slot0_instr (slot0_instr),
    .slot1_valid (slot1_valid),
    .slot1_pc    (slot1_pc),
    .slot1_instr (slot1_instr)
  );

  function automatic logic [15:0] parcel_at(input logic [31:0] pc);
    return imem.image[(pc >> 1) % IMAGE_PARCELS];
  endfunction

  // 32 bits wide only when both low bits are set.
  function automatic int instr_len(input logic [31:0] pc);
    logic [15:0] low;
    low = parcel_at(pc);
    return (low[1:0] == 2'b11) ? 4 : 2;
  endfunction

  function automatic logic [31:0] expected_instr(input logic [31:0] pc);
    if (instr_len(pc) == 4) begin
      return {parcel_at(pc + 32'd2), parcel_at(pc)};
    end
    return {16'b0, parcel_at(pc)};
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    value_errors++;
    $display("** Error [%s] %s: expected %h, actual %h at %0t", test_name, what,
             expected, actual, $time);
  endtask

  task automatic report_failure(input string what);
    other_errors++;
    $display("[%s] %s at %0t", test_name, what, $time);
  endtask

  // first quarter compressed only and the rest about half full width.
  task automatic fill_image();
    logic [15:0] p;
    for (int i = 0; i < IMAGE_PARCELS; i++) begin
      p = 16'($urandom);
      if (i < IMAGE_PARCELS / 4) begin
        p[1:0] = 2'($urandom % 3);
      end else if ($urandom % 2 == 0) begin
        p[1:0] = 2'b11;
      end
      imem.image[i] = p;
    end
    for (int i = 0; i < DELAY_SLOTS; i++) begin
      imem.delays[i] = 1 + $urandom % 4;
    end
  endtask

  task automatic check_slot(input int slot, input logic [31:0] pc, input logic [31:0] instr);
    int len;
    checks++;
    if (!stream_on) begin
      report_failure($sformatf("slot%0d issued before any redirect", slot));
    end else begin
      len = instr_len(exp_pc);
      if (issued == 0) begin
        first_pc = pc;
      end
      if (pc !== exp_pc) begin
        report_mismatch($sformatf("slot%0d pc", slot), exp_pc, pc);
      end
      if (instr !== expected_instr(exp_pc)) begin
        report_mismatch($sformatf("slot%0d instr", slot), expected_instr(exp_pc), instr);
      end
      if (len == 4 && exp_pc[2:1] == 2'b11) begin
        straddles++;
      end
      if (slot == 1) begin
        dual_cycles++;
      end
      issued++;
      exp_pc = exp_pc + len;
    end
  endtask

  // reference walker checks slot0 before slot1.
  always @(negedge clock) begin
    if (reset === 1'b1) begin
      if (issue_stall && (slot0_valid || slot1_valid)) begin
        report_failure("instruction issued while issue_stall is high");
      end
      if (slot1_valid && !slot0_valid) begin
        report_failure("slot1 valid without slot0");
      end
      if (slot0_valid) begin
        check_slot(0, slot0_pc, slot0_instr);
      end
      if (slot1_valid) begin
        check_slot(1, slot1_pc, slot1_instr);
      end
      // blocks are fetched from the aligned target upward.
      if (mem_valid === 1'b1) begin
        checks++;
        if (mem_addr !== exp_fetch) begin
          report_mismatch("mem_addr", exp_fetch, mem_addr);
        end
        exp_fetch = exp_fetch + 32'd8;
      end
    end
  end

  task automatic drive_redirect(input logic [31:0] target);
    @(posedge clock);
    #1;
    redirect    = 1'b1;
    redirect_pc = target;
    exp_pc      = target;
    exp_fetch   = {target[31:3], 3'b000};
    stream_on   = 1'b1;
    issued      = 0;
    dual_cycles = 0;
    straddles   = 0;
    @(posedge clock);
    #1;
    redirect = 1'b0;
  endtask

  task automatic wait_issued(input int count);
    while (issued < count) begin
      @(posedge clock);
    end
  endtask

  task automatic test_reset_idle();
    test_name = "reset_idle";
    repeat (IDLE_CYCLES) begin
      @(negedge clock);
      if (mem_valid !== 1'b0) begin
        report_mismatch("mem_valid", 32'd0, 32'(mem_valid));
      end
      if (slot0_valid !== 1'b0 || slot1_valid !== 1'b0) begin
        report_mismatch("slot valids", 32'd0, {30'd0, slot1_valid, slot0_valid});
      end
    end
  endtask

  task automatic test_compressed();
    test_name = "compressed";
    drive_redirect(32'h0000_0000);
    wait_issued(N_COMPRESSED);
    if (dual_cycles == 0) begin
      report_failure("no cycle issued two instructions");
    end
  endtask

  task automatic test_mixed();
    test_name = "mixed";
    drive_redirect(32'h0000_0100);
    wait_issued(N_MIXED);
    if (straddles == 0) begin
      report_failure("no 32-bit instruction crossed an 8-byte block");
    end
  endtask

  task automatic test_redirect_outstanding();
    test_name = "redirect";
    drive_redirect(32'h0000_0200);
    wait_issued(N_OLD_STREAM);
    // redirect right after a request is taken.
    @(negedge clock);
    while (mem_valid !== 1'b1) begin
      @(negedge clock);
    end
    drive_redirect(REDIRECT_TARGET);
    wait_issued(N_REDIRECT);
    if (first_pc !== REDIRECT_TARGET) begin
      report_mismatch("first pc", REDIRECT_TARGET, first_pc);
    end
  endtask

  task automatic test_stall();
    test_name = "stall";
    drive_redirect(32'h0000_0302);
    wait_issued(N_PRE_STALL);
    @(posedge clock);
    #1;
    issue_stall = 1'b1;
    repeat (STALL_CYCLES - QUIET_CYCLES) @(negedge clock);
    // a live fetch shows a request or a response in any four cycles.
    repeat (QUIET_CYCLES) begin
      @(negedge clock);
      if (mem_valid || mem_ready) begin
        report_failure("memory traffic while the buffer should be full");
      end
    end
    @(posedge clock);
    #1;
    issue_stall = 1'b0;
    wait_issued(N_PRE_STALL + N_POST_STALL);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLOCK_PERIOD);
    $display("watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    void'($urandom(75));
    redirect    = 1'b0;
    redirect_pc = '0;
    issue_stall = 1'b0;
    fill_image();
    wait (reset === 1'b1);
    test_reset_idle();
    test_compressed();
    test_mixed();
    test_redirect_outstanding();
    test_stall();
    $display("checks %0d, value errors %0d, other errors %0d", checks, value_errors,
             other_errors);
    if (value_errors + other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/tb_imem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_imem #(
  parameter int PARCELS     = 512,
  parameter int DELAY_SLOTS = 64
) (
  input  logic        clock,
  input  logic        mem_valid,
  input  logic [31:0] mem_addr,
  output logic        mem_ready,
  output logic [63:0] mem_rdata
);

  // program image and response latencies, both filled by the testbench.
  logic [15:0] image [PARCELS];
  int unsigned delays [DELAY_SLOTS];
  int unsigned req_count;
  int unsigned base;
  logic [31:0] req_addr;

  initial begin
    mem_ready = 1'b0;
    mem_rdata = '0;
    req_count = 0;
  end

  // one request at a time, answered 1 to 4 cycles later.
  always @(posedge clock) begin
    if (mem_valid === 1'b1) begin
      req_addr = mem_addr;
      base     = (req_addr >> 1) % PARCELS;
      repeat (delays[req_count % DELAY_SLOTS] - 1) @(posedge clock);
      req_count = req_count + 1;
      #1;
      mem_ready = 1'b1;
      mem_rdata = {image[base + 3], image[base + 2], image[base + 1], image[base]};
      @(posedge clock);
      #1;
      mem_ready = 1'b0;
    end
  end

endmodule

`default_nettype wire
